//--- source/farm_sensor_pkg.sv
// Sensor channel numbers, sample and flag types, averaging sizes
package farm_sensor_pkg;

    // ====================
    // Types
    // ====================
    typedef logic [7:0] sample_t;      // One reading or one average
    typedef logic [1:0] chan_t;        // Channel number
    typedef logic [3:0] chan_flags_t;  // Bit n belongs to channel n

    // ====================
    // Channel numbers
    // ====================
    localparam chan_t CHAN_SOIL  = 2'd0;  // Soil moisture
    localparam chan_t CHAN_TEMP  = 2'd1;  // Temperature
    localparam chan_t CHAN_HUMID = 2'd2;  // Humidity
    localparam chan_t CHAN_LIGHT = 2'd3;  // Light level

    localparam int NUM_CHAN = 4;

    // ====================
    // Averaging sizes
    // ====================
    // Average is a plain shift, so the depth stays a power of two
    localparam int HIST_DEPTH = 4;   // Samples per average
    localparam int HIST_IDX_W = 2;   // log2 of HIST_DEPTH
    localparam int SUM_W      = 10;  // Four 8-bit readings without overflow

endpackage

//--- source/farm_limits_pkg.sv
// Growing windows per channel and extreme reading values
package farm_limits_pkg;

    import farm_sensor_pkg::*;

    // ====================
    // Growing windows
    // ====================
    localparam sample_t SOIL_MIN  = 8'd140;  // Too dry below
    localparam sample_t SOIL_MAX  = 8'd210;  // Too wet above
    localparam sample_t TEMP_MIN  = 8'd100;  // Too cold
    localparam sample_t TEMP_MAX  = 8'd160;  // Too hot
    localparam sample_t HUMID_MIN = 8'd120;  // Air too dry
    localparam sample_t HUMID_MAX = 8'd190;  // Air too damp
    localparam sample_t LIGHT_MIN = 8'd80;   // Too dark
    localparam sample_t LIGHT_MAX = 8'd220;  // Too bright

    // Sensor rails, a reading pinned here means a broken sensor
    localparam sample_t EXTREME_LOW  = 8'd0;
    localparam sample_t EXTREME_HIGH = 8'd255;

    // ====================
    // Lookup by channel
    // ====================
    localparam sample_t limit_min [NUM_CHAN] = '{
        CHAN_SOIL:  SOIL_MIN,
        CHAN_TEMP:  TEMP_MIN,
        CHAN_HUMID: HUMID_MIN,
        CHAN_LIGHT: LIGHT_MIN
    };

    localparam sample_t limit_max [NUM_CHAN] = '{
        CHAN_SOIL:  SOIL_MAX,
        CHAN_TEMP:  TEMP_MAX,
        CHAN_HUMID: HUMID_MAX,
        CHAN_LIGHT: LIGHT_MAX
    };

endpackage

//--- source/sample_averager.sv
// Input stage, per-channel sample history and four-sample running average
`timescale 1ns/1ns

module sample_averager (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sample_strobe,  // One reading this cycle
    input  farm_sensor_pkg::chan_t   sample_chan,
    input  farm_sensor_pkg::sample_t sample_value,
    output logic                     avg_valid,      // One-cycle pulse
    output farm_sensor_pkg::chan_t   avg_chan,
    output farm_sensor_pkg::sample_t avg_value,
    output farm_sensor_pkg::sample_t avg_raw         // Reading behind avg_value
);

    import farm_sensor_pkg::*;

    // ====================
    // History storage
    // ====================
    sample_t               hist     [NUM_CHAN][HIST_DEPTH];  // Ring per channel
    logic [HIST_IDX_W-1:0] hist_idx [NUM_CHAN];              // Oldest slot per channel
    logic [SUM_W-1:0]      run_sum  [NUM_CHAN];              // Sum of the ring

    sample_t          oldest;   // Reading about to drop out
    logic [SUM_W-1:0] new_sum;  // Sum including the new reading

    // Swap the oldest reading for the new one in the sum
    always_comb begin
        oldest  = hist[sample_chan][hist_idx[sample_chan]];
        new_sum = run_sum[sample_chan] - SUM_W'(oldest) + SUM_W'(sample_value);
    end

    // ====================
    // Update and register
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < NUM_CHAN; c++) begin
                for (int d = 0; d < HIST_DEPTH; d++) begin
                    hist[c][d] <= '0;  // Reset zeros count in the first averages
                end
                hist_idx[c] <= '0;
                run_sum[c]  <= '0;
            end
            avg_valid <= 1'b0;
            avg_chan  <= '0;
            avg_value <= '0;
            avg_raw   <= '0;
        end else begin
            avg_valid <= sample_strobe;  // Drops back after one cycle
            if (sample_strobe) begin
                hist[sample_chan][hist_idx[sample_chan]] <= sample_value;
                hist_idx[sample_chan] <= hist_idx[sample_chan] + 1'b1;  // Wraps at depth
                run_sum[sample_chan]  <= new_sum;

                // Divide by the depth, truncated
                avg_value <= sample_t'(new_sum >> HIST_IDX_W);
                avg_chan  <= sample_chan;
                avg_raw   <= sample_value;
            end
        end
    end

endmodule

//--- source/condition_checker.sv
// Processing stage, window alerts and stuck or extreme faults per channel
`timescale 1ns/1ns

module condition_checker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         avg_valid,
    input  farm_sensor_pkg::chan_t       avg_chan,
    input  farm_sensor_pkg::sample_t     avg_value,
    input  farm_sensor_pkg::sample_t     avg_raw,
    output logic                         chk_valid,   // One-cycle pulse
    output farm_sensor_pkg::chan_t       chk_chan,
    output farm_sensor_pkg::sample_t     chk_value,   // Average passed through
    output farm_sensor_pkg::chan_flags_t alert_code,  // Outside growing window
    output farm_sensor_pkg::chan_flags_t fault_code   // Sensor looks broken
);

    import farm_sensor_pkg::*;
    import farm_limits_pkg::*;

    // ====================
    // Per-channel state
    // ====================
    sample_t last_raw [NUM_CHAN];  // Previous raw reading per channel

    logic too_low;   // Average under the window
    logic too_high;  // Average over the window
    logic stuck;     // Same raw reading twice in a row
    logic extreme;   // Average sitting on a rail

    // Checks run on the fresh average, not the one stored last time
    always_comb begin
        too_low  = avg_value < limit_min[avg_chan];
        too_high = avg_value > limit_max[avg_chan];
        stuck    = avg_raw == last_raw[avg_chan];
        extreme  = (avg_value == EXTREME_LOW) || (avg_value == EXTREME_HIGH);
    end

    // ====================
    // Code registers
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < NUM_CHAN; c++) begin
                last_raw[c] <= '0;
            end
            chk_valid  <= 1'b0;
            chk_chan   <= '0;
            chk_value  <= '0;
            alert_code <= '0;
            fault_code <= '0;
        end else begin
            chk_valid <= avg_valid;
            if (avg_valid) begin
                // Only the sampled channel's bits move
                alert_code[avg_chan] <= too_low | too_high;
                fault_code[avg_chan] <= stuck | extreme;
                last_raw[avg_chan]   <= avg_raw;  // Compared against next reading

                chk_chan  <= avg_chan;
                chk_value <= avg_value;
            end
        end
    end

endmodule

//--- source/alarm_reporter.sv
// Output stage, buzzer and the two output bytes
`timescale 1ns/1ns

module alarm_reporter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         chk_valid,
    input  farm_sensor_pkg::sample_t     chk_value,
    input  farm_sensor_pkg::chan_flags_t alert_code,
    input  farm_sensor_pkg::chan_flags_t fault_code,
    output logic [7:0]                   uo_out,   // Buzzer and average
    output logic [7:0]                   uio_out   // Fault and alert codes
);

    logic buzzer_next;  // Any channel out of window or faulty

    always_comb begin
        buzzer_next = (|alert_code) | (|fault_code);
    end

    // ====================
    // Output bytes
    // ====================
    // Values hold between pulses, so the pins show the last sample seen
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uo_out  <= 8'h00;
            uio_out <= 8'h00;
        end else if (chk_valid) begin
            uo_out  <= {buzzer_next, chk_value[6:0]};  // MSB of the average is dropped
            uio_out <= {fault_code, alert_code};       // Faults on top nibble
        end
    end

endmodule

//--- source/tt_um_precision_farming.sv
// Tiny Tapeout top level, pin decoding and the three monitor stages
`timescale 1ns/1ns

module tt_um_precision_farming (
    input  logic [7:0] ui_in,    // Sensor reading
    output logic [7:0] uo_out,   // Buzzer and shown average
    input  logic [7:0] uio_in,   // Channel select in bits 1:0
    output logic [7:0] uio_out,  // Fault and alert codes
    output logic [7:0] uio_oe,   // Bidirectional pin direction
    input  logic       ena,      // High while a reading is present
    input  logic       clk,
    input  logic       rst_n
);

    import farm_sensor_pkg::*;

    // ====================
    // Pin decoding
    // ====================
    logic    sample_strobe;
    chan_t   sample_chan;
    sample_t sample_value;

    assign sample_strobe = ena;
    assign sample_chan   = uio_in[1:0];
    assign sample_value  = ui_in;
    assign uio_oe        = 8'hFF;  // All bidirectional pins drive out

    // Averager to checker
    logic    avg_valid;
    chan_t   avg_chan;
    sample_t avg_value;
    sample_t avg_raw;

    // Checker to reporter
    logic        chk_valid;
    sample_t     chk_value;
    chan_flags_t alert_code;
    chan_flags_t fault_code;

    // ====================
    // Stages
    // ====================
    sample_averager u_averager (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_strobe (sample_strobe),
        .sample_chan   (sample_chan),
        .sample_value  (sample_value),
        .avg_valid     (avg_valid),
        .avg_chan      (avg_chan),
        .avg_value     (avg_value),
        .avg_raw       (avg_raw)
    );

    condition_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .avg_valid  (avg_valid),
        .avg_chan   (avg_chan),
        .avg_value  (avg_value),
        .avg_raw    (avg_raw),
        .chk_valid  (chk_valid),
        .chk_chan   (),
        .chk_value  (chk_value),
        .alert_code (alert_code),
        .fault_code (fault_code)
    );

    alarm_reporter u_reporter (
        .clk        (clk),
        .rst_n      (rst_n),
        .chk_valid  (chk_valid),
        .chk_value  (chk_value),
        .alert_code (alert_code),
        .fault_code (fault_code),
        .uo_out     (uo_out),
        .uio_out    (uio_out)
    );

endmodule

//--- tests/tb_farm_monitor.sv
// Farm monitor testbench with clock, reset, LFSR stimulus, reference model, checks and report
`timescale 1ns/1ns

module tb_farm_monitor;

    localparam int RESET_CYCLES = 16;
    // Two resets, then tests 1 to 6 in order
    localparam int TEST_CYCLES  = 2 * (RESET_CYCLES + 1) + 1 + 42 + 96 + 11 + 13 + 48;
    localparam int MAX_CYCLES   = TEST_CYCLES + 100;  // Margin for drain cycles

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    tt_um_precision_farming dut0 (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    always #2 clk = ~clk;  // 4 ns period

    // ====================
    // Reference model state
    // ====================
    logic [7:0]  m_hist [4][4];  // Last four readings per channel
    logic [1:0]  m_idx  [4];     // Next slot to overwrite
    logic [7:0]  m_last [4];     // Previous raw reading
    logic [3:0]  m_alert;
    logic [3:0]  m_fault;
    logic        p_valid [3];    // Predictions in flight, index = age
    logic [7:0]  p_uo    [3];
    logic [7:0]  p_uio   [3];
    logic [7:0]  exp_uo;         // What the pins show now
    logic [7:0]  exp_uio;
    logic [31:0] lfsr;
    int          cycle_count;
    int          check_count;
    int          error_count;
    int          test_num;
    int          test_err_start;
    int          clean_tests;

    // Growing windows per channel
    function automatic logic [7:0] low_limit(input logic [1:0] c);
        case (c)
            2'd0:    return 8'd140;
            2'd1:    return 8'd100;
            2'd2:    return 8'd120;
            default: return 8'd80;
        endcase
    endfunction

    function automatic logic [7:0] high_limit(input logic [1:0] c);
        case (c)
            2'd0:    return 8'd210;
            2'd1:    return 8'd160;
            2'd2:    return 8'd190;
            default: return 8'd220;
        endcase
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    task automatic take_bits(input int n, output logic [7:0] val);
        logic fb;
        val = '0;
        repeat (n) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            val  = {val[6:0], lfsr[31]};
            lfsr = {lfsr[30:0], fb};
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] expv, input logic [7:0] act);
        check_count++;
        assert (act === expv) else begin
            $display("[ERROR] %s expected 0x%02h actual 0x%02h", name, expv, act);
            error_count++;
        end
    endtask

    // Reference model for one accepted reading
    task automatic model_sample(input logic [1:0] c, input logic [7:0] v,
                                output logic [7:0] uo, output logic [7:0] uio);
        int         sum;
        logic [7:0] avg;
        m_hist[c][m_idx[c]] = v;
        m_idx[c] = m_idx[c] + 2'd1;
        sum = 0;
        for (int d = 0; d < 4; d++) sum += m_hist[c][d];
        avg = 8'(sum / 4);  // Truncated mean
        m_alert[c] = (avg < low_limit(c)) || (avg > high_limit(c));
        m_fault[c] = (v == m_last[c]) || (avg == 8'd0) || (avg == 8'd255);
        m_last[c]  = v;
        uo  = {(|m_alert) | (|m_fault), avg[6:0]};
        uio = {m_fault, m_alert};
    endtask

    // Check the pins, then drive the next cycle's inputs
    task automatic cycle(input logic en, input logic [1:0] c, input logic [7:0] v);
        logic [7:0] junk;
        @(negedge clk);
        if (p_valid[2]) begin  // Sample from three negedges back has landed
            exp_uo  = p_uo[2];
            exp_uio = p_uio[2];
        end
        check_byte("uo_out", exp_uo, uo_out);
        check_byte("uio_out", exp_uio, uio_out);
        check_byte("uio_oe", 8'hFF, uio_oe);
        for (int i = 2; i > 0; i--) begin
            p_valid[i] = p_valid[i-1];
            p_uo[i]    = p_uo[i-1];
            p_uio[i]   = p_uio[i-1];
        end
        take_bits(6, junk);  // Unused upper uio_in bits
        ena        = en;
        uio_in     = {junk[5:0], c};
        ui_in      = v;
        p_valid[0] = en;
        if (en) model_sample(c, v, p_uo[0], p_uio[0]);
    endtask

    task automatic idle_cycles(input int n);
        logic [7:0] v;
        repeat (n) begin
            take_bits(8, v);
            cycle(1'b0, 2'd0, v);  // Random ui_in, ena low
        end
    endtask

    task automatic random_sample();
        logic [7:0] c;
        logic [7:0] v;
        take_bits(2, c);
        take_bits(8, v);
        cycle(1'b1, c[1:0], v);
    endtask

    // Four readings spread by +-1 and +-3 around a centre
    task automatic four_around(input logic [1:0] c, input logic [7:0] centre);
        cycle(1'b1, c, centre - 8'd3);
        cycle(1'b1, c, centre - 8'd1);
        cycle(1'b1, c, centre + 8'd1);
        cycle(1'b1, c, centre + 8'd3);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        ena   = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        for (int c = 0; c < 4; c++) begin
            for (int d = 0; d < 4; d++) m_hist[c][d] = '0;
            m_idx[c]  = '0;
            m_last[c] = '0;
        end
        for (int i = 0; i < 3; i++) p_valid[i] = 1'b0;
        m_alert = '0;
        m_fault = '0;
        exp_uo  = '0;
        exp_uio = '0;
        rst_n   = 1'b1;
    endtask

    task automatic start_test();
        test_num++;
        test_err_start = error_count;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d errors", test_num, name, error_count - test_err_start);
        if (error_count == test_err_start) clean_tests++;
    endtask

    // ====================
    // Cycle limit
    // ====================
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped: cycle limit of %0d reached before the tests ended", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic [7:0] c;
        clk    = 1'b0;
        rst_n  = 1'b0;
        ena    = 1'b0;
        ui_in  = '0;
        uio_in = '0;
        lfsr   = 32'h3379;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        test_num    = 0;
        clean_tests = 0;
        apply_reset();

        start_test();  // Reset values
        cycle(1'b0, 2'd0, 8'h00);
        end_test("reset");

        start_test();  // Averaging, one channel then random mix
        cycle(1'b1, 2'd0, 8'd150);
        cycle(1'b1, 2'd0, 8'd170);
        cycle(1'b1, 2'd0, 8'd190);
        cycle(1'b1, 2'd0, 8'd210);
        idle_cycles(4);
        check_byte("uo_out[6:0]", {1'b0, 7'(720 / 4)}, {1'b0, uo_out[6:0]});
        repeat (30) random_sample();
        idle_cycles(4);
        end_test("averaging");

        start_test();  // Inside, below, above each window
        for (int ch = 0; ch < 4; ch++) begin
            c = 8'(ch);
            four_around(c[1:0], 8'((low_limit(c[1:0]) + high_limit(c[1:0])) / 2));
            idle_cycles(4);
            check_byte("alert bit", 8'h00, {7'b0, uio_out[ch]});
            four_around(c[1:0], low_limit(c[1:0]) - 8'd40);
            idle_cycles(4);
            check_byte("alert bit", 8'h01, {7'b0, uio_out[ch]});
            check_byte("buzzer", 8'h01, {7'b0, uo_out[7]});  // Set alert forces the buzzer
            four_around(c[1:0], high_limit(c[1:0]) + 8'd20);
            idle_cycles(4);
            check_byte("alert bit", 8'h01, {7'b0, uio_out[ch]});
        end
        end_test("window alerts");

        start_test();  // Stuck temperature sensor
        cycle(1'b1, 2'd1, 8'd130);
        cycle(1'b1, 2'd1, 8'd130);
        idle_cycles(4);
        check_byte("fault bit", 8'h01, {7'b0, uio_out[5]});
        cycle(1'b1, 2'd1, 8'd135);
        idle_cycles(4);
        check_byte("fault bit", 8'h00, {7'b0, uio_out[5]});
        end_test("stuck fault");

        start_test();  // Rails: light pinned high, soil average 0
        repeat (4) cycle(1'b1, 2'd3, 8'd255);
        idle_cycles(4);
        check_byte("fault bit", 8'h01, {7'b0, uio_out[7]});
        check_byte("buzzer", 8'h01, {7'b0, uo_out[7]});
        apply_reset();
        cycle(1'b1, 2'd0, 8'd3);
        idle_cycles(4);
        check_byte("fault bit", 8'h01, {7'b0, uio_out[4]});
        check_byte("buzzer", 8'h01, {7'b0, uo_out[7]});
        end_test("extreme fault");

        start_test();  // Hold with ena low, then resume
        repeat (4) random_sample();
        idle_cycles(20);
        repeat (20) random_sample();
        idle_cycles(4);
        end_test("hold");

        $display("summary: %0d checks, %0d errors, %0d of %0d tests clean",
                 check_count, error_count, clean_tests, test_num);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
source/farm_sensor_pkg.sv
source/farm_limits_pkg.sv
source/sample_averager.sv
source/condition_checker.sv
source/alarm_reporter.sv
source/tt_um_precision_farming.sv
tests/tb_farm_monitor.sv
